// File: build.f
+incdir+tb
common/rv_pkg.sv
core/rv_fetch.sv
core/rv_decode.sv
core/rv_regfile.sv
core/rv_execute.sv
core/rv_result.sv
core/rv_core.sv
tb/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the RV32I core testbench with Verilator

LOG=sim.log
OBJ=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_core -f build.f --Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

# The log decides the outcome
if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tb/rv_program_table.svh
`ifndef RV_PROGRAM_TABLE_SVH
`define RV_PROGRAM_TABLE_SVH

// Expected retire of one instruction, in program order
typedef struct packed {
    int          run;
    logic [31:0] pc;
    logic [31:0] insn;
    logic        rd_we;
    logic [4:0]  rd;
    logic [31:0] rd_data;
} row_t;

localparam int NUM_RUNS   = 2;
localparam int IMEM_WORDS = 256;

logic [31:0] prog_words [NUM_RUNS][IMEM_WORDS];
int          prog_len   [NUM_RUNS];
logic        exp_trap   [NUM_RUNS];
row_t        rows       [$];

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                       input logic [19:0] imm);
    return {imm, rd, opc};
endfunction

// Offsets are byte offsets, bit 0 is dropped by the format
function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// Word the core must jump over or never reach
task automatic skipped_word(input int run, input logic [31:0] word);
    prog_words[run][prog_len[run]] = word;
    prog_len[run]++;
endtask

task automatic writes_reg(input int run, input logic [31:0] word,
                          input logic [4:0] rd, input logic [31:0] data);
    row_t row;
    row.run     = run;
    row.pc      = prog_len[run] * 4;
    row.insn    = word;
    row.rd_we   = 1'b1;
    row.rd      = rd;
    row.rd_data = data;
    rows.push_back(row);
    skipped_word(run, word);
endtask

// Retires without a register write
task automatic retires_only(input int run, input logic [31:0] word);
    row_t row;
    row.run     = run;
    row.pc      = prog_len[run] * 4;
    row.insn    = word;
    row.rd_we   = 1'b0;
    row.rd      = 5'd0;
    row.rd_data = 32'h0;
    rows.push_back(row);
    skipped_word(run, word);
endtask

task automatic build_tables();
    logic [31:0] poison;
    poison      = i_type(OPC_OP_IMM, 3'b000, 5'd31, 5'd0, 12'h7FF);
    prog_len[0] = 0;
    prog_len[1] = 0;
    exp_trap[0] = 1'b0;
    exp_trap[1] = 1'b1;

    // Operands x1 = -8 and x2 = 3
    writes_reg(0, i_type(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'hFF8), 5'd1, 32'hFFFF_FFF8);
    writes_reg(0, i_type(OPC_OP_IMM, 3'b000, 5'd2, 5'd0, 12'h003), 5'd2, 32'h0000_0003);
    writes_reg(0, r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'hFFFF_FFFB);
    writes_reg(0, r_type(7'h20, 3'b000, 5'd4, 5'd2, 5'd1), 5'd4, 32'h0000_000B);
    // SRA keeps the sign, SRL shifts in zeros
    writes_reg(0, r_type(7'h20, 3'b101, 5'd5, 5'd1, 5'd2), 5'd5, 32'hFFFF_FFFF);
    writes_reg(0, r_type(7'h00, 3'b101, 5'd6, 5'd1, 5'd2), 5'd6, 32'h1FFF_FFFF);
    writes_reg(0, r_type(7'h00, 3'b010, 5'd7, 5'd1, 5'd2), 5'd7, 32'h0000_0001);
    writes_reg(0, r_type(7'h00, 3'b011, 5'd8, 5'd1, 5'd2), 5'd8, 32'h0000_0000);
    writes_reg(0, r_type(7'h00, 3'b001, 5'd9, 5'd2, 5'd2), 5'd9, 32'h0000_0018);
    writes_reg(0, r_type(7'h00, 3'b100, 5'd10, 5'd1, 5'd2), 5'd10, 32'hFFFF_FFFB);
    writes_reg(0, r_type(7'h00, 3'b110, 5'd11, 5'd1, 5'd2), 5'd11, 32'hFFFF_FFFB);
    writes_reg(0, r_type(7'h00, 3'b111, 5'd12, 5'd1, 5'd9), 5'd12, 32'h0000_0018);
    writes_reg(0, i_type(OPC_OP_IMM, 3'b111, 5'd13, 5'd1, 12'h0F0), 5'd13, 32'h0000_00F0);
    writes_reg(0, i_type(OPC_OP_IMM, 3'b110, 5'd14, 5'd2, 12'h100), 5'd14, 32'h0000_0103);
    writes_reg(0, i_type(OPC_OP_IMM, 3'b100, 5'd15, 5'd1, 12'hFFF), 5'd15, 32'h0000_0007);
    writes_reg(0, i_type(OPC_OP_IMM, 3'b010, 5'd16, 5'd1, 12'hFF9), 5'd16, 32'h0000_0001);
    writes_reg(0, i_type(OPC_OP_IMM, 3'b011, 5'd17, 5'd2, 12'hFFF), 5'd17, 32'h0000_0001);
    writes_reg(0, i_type(OPC_OP_IMM, 3'b001, 5'd18, 5'd2, 12'h004), 5'd18, 32'h0000_0030);
    writes_reg(0, i_type(OPC_OP_IMM, 3'b101, 5'd19, 5'd1, 12'h401), 5'd19, 32'hFFFF_FFFC);
    writes_reg(0, i_type(OPC_OP_IMM, 3'b101, 5'd20, 5'd1, 12'h01C), 5'd20, 32'h0000_000F);
    // Write to x0 is dropped, then x0 reads as zero
    retires_only(0, i_type(OPC_OP_IMM, 3'b000, 5'd0, 5'd2, 12'h005));
    writes_reg(0, r_type(7'h00, 3'b000, 5'd21, 5'd0, 5'd2), 5'd21, 32'h0000_0003);
    writes_reg(0, u_type(OPC_LUI, 5'd22, 20'h12345), 5'd22, 32'h1234_5000);
    writes_reg(0, u_type(OPC_AUIPC, 5'd23, 20'h00001), 5'd23, 32'h0000_105C);

    // Each funct3 once not taken, then once taken over a poison word
    retires_only(0, b_type(3'b000, 5'd1, 5'd2, 13'd8));
    retires_only(0, b_type(3'b000, 5'd2, 5'd2, 13'd8));
    skipped_word(0, poison);
    retires_only(0, b_type(3'b001, 5'd2, 5'd2, 13'd8));
    retires_only(0, b_type(3'b001, 5'd1, 5'd2, 13'd8));
    skipped_word(0, poison);
    retires_only(0, b_type(3'b100, 5'd2, 5'd1, 13'd8));
    retires_only(0, b_type(3'b100, 5'd1, 5'd2, 13'd8));
    skipped_word(0, poison);
    retires_only(0, b_type(3'b101, 5'd1, 5'd2, 13'd8));
    retires_only(0, b_type(3'b101, 5'd2, 5'd1, 13'd8));
    skipped_word(0, poison);
    retires_only(0, b_type(3'b110, 5'd1, 5'd2, 13'd8));
    retires_only(0, b_type(3'b110, 5'd2, 5'd1, 13'd8));
    skipped_word(0, poison);
    retires_only(0, b_type(3'b111, 5'd2, 5'd1, 13'd8));
    retires_only(0, b_type(3'b111, 5'd1, 5'd2, 13'd8));
    skipped_word(0, poison);

    // JAL from 0xA8 to 0xB4, JALR through odd 0xC5 lands on 0xC4
    writes_reg(0, j_type(5'd24, 21'd12), 5'd24, 32'h0000_00AC);
    skipped_word(0, poison);
    skipped_word(0, poison);
    writes_reg(0, i_type(OPC_OP_IMM, 3'b000, 5'd25, 5'd0, 12'h0C5), 5'd25, 32'h0000_00C5);
    writes_reg(0, i_type(OPC_JALR, 3'b000, 5'd26, 5'd25, 12'h000), 5'd26, 32'h0000_00BC);
    skipped_word(0, poison);
    skipped_word(0, poison);
    writes_reg(0, r_type(7'h00, 3'b000, 5'd27, 5'd26, 5'd24), 5'd27, 32'h0000_0168);
    retires_only(0, i_type(OPC_SYSTEM, 3'b000, 5'd0, 5'd0, 12'h001));
    skipped_word(0, poison);

    // Second run stops on an all-ones word
    writes_reg(1, i_type(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'h7FF), 5'd1, 32'h0000_07FF);
    writes_reg(1, u_type(OPC_LUI, 5'd2, 20'hFFFFF), 5'd2, 32'hFFFF_F000);
    writes_reg(1, r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'hFFFF_F7FF);
    retires_only(1, 32'hFFFF_FFFF);
    skipped_word(1, poison);
endtask

`endif

// File: tb/tb_rv_core.sv
`default_nettype none
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    `include "rv_program_table.svh"

    localparam int RESET_CYCLES = 10;
    localparam int HALT_WATCH   = 8;
    localparam int MARGIN       = 20;

    logic            clk;
    logic            rst_n_i;
    logic [XLEN-1:0] imem_addr_o;
    logic [31:0]     imem_rdata_i;
    retire_t         retire_o;
    logic            halted_o;
    logic            trap_o;

    logic [31:0] imem [IMEM_WORDS];
    int          errors;
    int          checked;
    int          cycles;
    int          cycle_limit;

    rv_core #(
        .RESET_PC(32'h0000_0000)
    ) DUT (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .retire_o     (retire_o),
        .halted_o     (halted_o),
        .trap_o       (trap_o)
    );

    always #2 clk = ~clk;

    // Word at the presented address arrives one edge later
    always @(posedge clk) begin
        imem_rdata_i <= imem[imem_addr_o[9:2]];
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("ERROR: timeout after %0d cycles, the run did not finish", cycles);
            $display("Summary: %0d errors, %0d retires checked", errors + 1, checked);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                 $time, name, exp_v, act_v);
        errors++;
    endtask

    // Unused words get random filler
    task automatic load_memory(input int run);
        int a;
        for (a = 0; a < IMEM_WORDS; a++) begin
            if (a < prog_len[run]) begin
                imem[a] = prog_words[run][a];
            end else begin
                imem[a] = $urandom;
            end
        end
    endtask

    task automatic apply_reset(input int run);
        @(posedge clk);
        rst_n_i <= 1'b0;
        @(negedge clk);
        load_memory(run);
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
    endtask

    task automatic compare_retire(input row_t row);
        if (retire_o.pc !== row.pc) begin
            report_mismatch("retire_o.pc", row.pc, retire_o.pc);
        end
        if (retire_o.insn !== row.insn) begin
            report_mismatch("retire_o.insn", row.insn, retire_o.insn);
        end
        if (retire_o.rd_we !== row.rd_we) begin
            report_mismatch("retire_o.rd_we", 32'(row.rd_we), 32'(retire_o.rd_we));
        end
        // Destination only matters when a register is written
        if (row.rd_we && retire_o.rd !== row.rd) begin
            report_mismatch("retire_o.rd", 32'(row.rd), 32'(retire_o.rd));
        end
        if (row.rd_we && retire_o.rd_data !== row.rd_data) begin
            report_mismatch("retire_o.rd_data", row.rd_data, retire_o.rd_data);
        end
    endtask

    task automatic check_run(input int run);
        logic            short_run;
        logic [XLEN-1:0] held_addr;
        int              n;
        short_run = 1'b0;
        held_addr = '0;
        @(negedge clk);
        if (halted_o !== 1'b0) begin
            report_mismatch("halted_o", 32'd0, 32'(halted_o));
        end
        if (trap_o !== 1'b0) begin
            report_mismatch("trap_o", 32'd0, 32'(trap_o));
        end
        foreach (rows[k]) begin
            if (rows[k].run == run && !short_run) begin
                // Halted core keeps presenting the pc of its last retire
                held_addr = rows[k].pc;
                while (!retire_o.valid && !halted_o) begin
                    @(negedge clk);
                end
                if (!retire_o.valid) begin
                    $display("ERROR at %0t: run %0d halted before pc %h retired",
                             $time, run, rows[k].pc);
                    errors++;
                    short_run = 1'b1;
                end else begin
                    compare_retire(rows[k]);
                    checked++;
                    @(negedge clk);
                end
            end
        end
        // Cycle after the last expected retire
        if (retire_o.valid) begin
            $display("ERROR at %0t: run %0d retired pc %h beyond the end of the table",
                     $time, run, retire_o.pc);
            errors++;
        end
        if (halted_o !== 1'b1) begin
            report_mismatch("halted_o", 32'd1, 32'(halted_o));
        end
        if (trap_o !== exp_trap[run]) begin
            report_mismatch("trap_o", 32'(exp_trap[run]), 32'(trap_o));
        end
        for (n = 0; n < HALT_WATCH; n++) begin
            @(negedge clk);
            if (retire_o.valid) begin
                $display("ERROR at %0t: run %0d retired pc %h while halted",
                         $time, run, retire_o.pc);
                errors++;
            end
            if (imem_addr_o !== held_addr) begin
                report_mismatch("imem_addr_o", held_addr, imem_addr_o);
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        imem_rdata_i = 32'h0;
        errors       = 0;
        checked      = 0;
        cycles       = 0;
        void'($urandom(68896));
        build_tables();
        cycle_limit = rows.size() + NUM_RUNS * (RESET_CYCLES + HALT_WATCH) + MARGIN;
        for (int run = 0; run < NUM_RUNS; run++) begin
            apply_reset(run);
            check_run(run);
        end
        $display("Summary: %0d errors, %0d of %0d retires checked",
                 errors, checked, rows.size());
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: core/rv_core.sv
`default_nettype none
`timescale 1ns/1ps

module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    // Instruction memory, one-cycle read
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    input  logic [31:0]             imem_rdata_i,
    output rv_pkg::retire_t         retire_o,
    output logic                    halted_o,
    output logic                    trap_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc;
    rv_inst_u        inst;
    logic            inst_valid;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [4:0]      rd_addr;
    logic [XLEN-1:0] imm;
    ctrl_t           ctrl;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] alu_result;
    logic            branch_taken;
    logic [XLEN-1:0] target;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [XLEN-1:0] rf_wdata;

    rv_fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .imem_rdata_i   (imem_rdata_i),
        .ctrl_i         (ctrl),
        .branch_taken_i (branch_taken),
        .target_i       (target),
        .imem_addr_o    (imem_addr_o),
        .pc_o           (pc),
        .inst_o         (inst),
        .inst_valid_o   (inst_valid),
        .halted_o       (halted_o),
        .trap_o         (trap_o)
    );

    rv_decode u_decode (
        .inst_i     (inst),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr),
        .imm_o      (imm),
        .ctrl_o     (ctrl)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

    rv_execute u_execute (
        .pc_i           (pc),
        .rs1_data_i     (rdata1),
        .rs2_data_i     (rdata2),
        .imm_i          (imm),
        .ctrl_i         (ctrl),
        .alu_result_o   (alu_result),
        .branch_taken_o (branch_taken),
        .target_o       (target)
    );

    rv_result u_result (
        .pc_i         (pc),
        .inst_i       (inst),
        .inst_valid_i (inst_valid),
        .halted_i     (halted_o),
        .ctrl_i       (ctrl),
        .rd_addr_i    (rd_addr),
        .alu_result_i (alu_result),
        .rf_we_o      (rf_we),
        .rf_waddr_o   (rf_waddr),
        .rf_wdata_o   (rf_wdata),
        .retire_o     (retire_o)
    );

endmodule

`default_nettype wire

// File: core/rv_result.sv
`default_nettype none
`timescale 1ns/1ps

module rv_result (
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    input  rv_pkg::rv_inst_u        inst_i,
    input  logic                    inst_valid_i,
    input  logic                    halted_i,
    input  rv_pkg::ctrl_t           ctrl_i,
    input  logic [4:0]              rd_addr_i,
    input  logic [rv_pkg::XLEN-1:0] alu_result_i,
    output logic                    rf_we_o,
    output logic [4:0]              rf_waddr_o,
    output logic [rv_pkg::XLEN-1:0] rf_wdata_o,
    output rv_pkg::retire_t         retire_o
);
    import rv_pkg::*;

    logic live;

    // Nothing commits before the first word or after halt
    assign live = inst_valid_i && !halted_i;

    assign rf_wdata_o = (ctrl_i.wb_sel == WB_PC4) ? pc_i + XLEN'(4) : alu_result_i;
    assign rf_waddr_o = rd_addr_i;
    assign rf_we_o    = live && ctrl_i.rf_we && (rd_addr_i != 5'd0);

    always_comb begin
        retire_o.valid   = live;
        retire_o.pc      = pc_i;
        retire_o.insn    = inst_i;
        retire_o.rd_we   = rf_we_o;
        retire_o.rd      = rd_addr_i;
        // Data shows zero when no register is written
        retire_o.rd_data = rf_we_o ? rf_wdata_o : '0;
    end

endmodule

`default_nettype wire

// File: core/rv_execute.sv
`default_nettype none
`timescale 1ns/1ps

module rv_execute (
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
    input  logic [rv_pkg::XLEN-1:0] imm_i,
    input  rv_pkg::ctrl_t           ctrl_i,
    output logic [rv_pkg::XLEN-1:0] alu_result_o,
    output logic                    branch_taken_o,
    output logic [rv_pkg::XLEN-1:0] target_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [4:0]      shamt;
    logic [XLEN-1:0] jalr_sum;
    logic            cond_met;

    always_comb begin
        case (ctrl_i.op1_sel)
            OP1_PC:   op1 = pc_i;
            OP1_ZERO: op1 = '0;
            default:  op1 = rs1_data_i;
        endcase
    end

    assign op2   = (ctrl_i.op2_sel == OP2_IMM) ? imm_i : rs2_data_i;
    assign shamt = op2[4:0];

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD:  alu_result_o = op1 + op2;
            ALU_SUB:  alu_result_o = op1 - op2;
            ALU_SLL:  alu_result_o = op1 << shamt;
            ALU_SLT:  alu_result_o = XLEN'($signed(op1) < $signed(op2));
            ALU_SLTU: alu_result_o = XLEN'(op1 < op2);
            ALU_XOR:  alu_result_o = op1 ^ op2;
            ALU_SRL:  alu_result_o = op1 >> shamt;
            ALU_SRA:  alu_result_o = $unsigned($signed(op1) >>> shamt);
            ALU_OR:   alu_result_o = op1 | op2;
            ALU_AND:  alu_result_o = op1 & op2;
            default:  alu_result_o = op2;
        endcase
    end

    // Branches always compare the two registers
    always_comb begin
        case (ctrl_i.funct3)
            3'b000:  cond_met = (rs1_data_i == rs2_data_i);
            3'b001:  cond_met = (rs1_data_i != rs2_data_i);
            3'b100:  cond_met = ($signed(rs1_data_i) < $signed(rs2_data_i));
            3'b101:  cond_met = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            3'b110:  cond_met = (rs1_data_i < rs2_data_i);
            3'b111:  cond_met = (rs1_data_i >= rs2_data_i);
            default: cond_met = 1'b0;
        endcase
    end

    assign branch_taken_o = (ctrl_i.pc_sel == PC_BRANCH) && cond_met;

    // JALR drops bit 0 of the sum
    assign jalr_sum = rs1_data_i + imm_i;
    assign target_o = (ctrl_i.pc_sel == PC_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                 : pc_i + imm_i;

    // Decode must keep the branch select and its flag in step
    always_comb begin
        a_taken_is_branch: assert (!branch_taken_o || ctrl_i.is_branch)
            else $error("execute: branch taken without is_branch");
    end

endmodule

`default_nettype wire

// File: core/rv_regfile.sv
`default_nettype none
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk,
    input  logic [4:0]              raddr1_i,
    input  logic [4:0]              raddr2_i,
    output logic [rv_pkg::XLEN-1:0] rdata1_o,
    output logic [rv_pkg::XLEN-1:0] rdata2_o,
    input  logic                    we_i,
    input  logic [4:0]              waddr_i,
    input  logic [rv_pkg::XLEN-1:0] wdata_i
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

    // Result stage filters x0 writes before they get here
    a_no_x0_write: assert property (@(posedge clk) !(we_i && waddr_i == 5'd0))
        else $error("regfile: write enable reached x0");

endmodule

`default_nettype wire

// File: core/rv_decode.sv
`default_nettype none
`timescale 1ns/1ps

module rv_decode (
    input  rv_pkg::rv_inst_u        inst_i,
    output logic [4:0]              rs1_addr_o,
    output logic [4:0]              rs2_addr_o,
    output logic [4:0]              rd_addr_o,
    output logic [rv_pkg::XLEN-1:0] imm_o,
    output rv_pkg::ctrl_t           ctrl_o
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // Shared by register and immediate forms, alt picks SUB or SRA
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode     = inst_i.r.opcode;
    assign funct3     = inst_i.i.funct3;
    assign funct7     = inst_i.r.funct7;
    assign rs1_addr_o = inst_i.s.rs1;
    assign rs2_addr_o = inst_i.s.rs2;
    assign rd_addr_o  = inst_i.r.rd;

    // Sign-extended immediate per format
    always_comb begin
        case (opcode)
            OPC_OP_IMM,
            OPC_JALR:   imm_o = {{20{inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
            OPC_LUI,
            OPC_AUIPC:  imm_o = {inst_i.u.imm_31_12, 12'b0};
            OPC_JAL:    imm_o = {{12{inst_i.j.imm_20}}, inst_i.j.imm_19_12,
                                 inst_i.j.imm_11, inst_i.j.imm_10_1, 1'b0};
            OPC_BRANCH: imm_o = {{20{inst_i.b.imm_12}}, inst_i.b.imm_11,
                                 inst_i.b.imm_10_5, inst_i.b.imm_4_1, 1'b0};
            default:    imm_o = '0;
        endcase
    end

    always_comb begin
        ctrl_o           = '0;
        ctrl_o.alu_op    = ALU_ADD;
        ctrl_o.op1_sel   = OP1_RS1;
        ctrl_o.op2_sel   = OP2_RS2;
        ctrl_o.pc_sel    = PC_PLUS4;
        ctrl_o.wb_sel    = WB_ALU;
        ctrl_o.funct3    = funct3;

        case (opcode)
            OPC_OP: begin
                ctrl_o.rf_we  = 1'b1;
                ctrl_o.alu_op = alu_from_funct3(funct3, funct7[5]);
                if (!(funct7 == 7'h00 ||
                      (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
                    ctrl_o.illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                ctrl_o.rf_we   = 1'b1;
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.alu_op  = alu_from_funct3(funct3,
                                                 funct3 == 3'b101 && funct7[5]);
                // Shift amounts fit in five bits, upper field is the shift kind
                if (funct3 == 3'b001 && funct7 != 7'h00) begin
                    ctrl_o.illegal = 1'b1;
                end
                if (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20) begin
                    ctrl_o.illegal = 1'b1;
                end
            end
            OPC_LUI: begin
                ctrl_o.rf_we   = 1'b1;
                ctrl_o.op1_sel = OP1_ZERO;
                ctrl_o.op2_sel = OP2_IMM;
            end
            OPC_AUIPC: begin
                ctrl_o.rf_we   = 1'b1;
                ctrl_o.op1_sel = OP1_PC;
                ctrl_o.op2_sel = OP2_IMM;
            end
            OPC_JAL: begin
                ctrl_o.rf_we  = 1'b1;
                ctrl_o.pc_sel = PC_JAL;
                ctrl_o.wb_sel = WB_PC4;
            end
            OPC_JALR: begin
                ctrl_o.rf_we   = 1'b1;
                ctrl_o.pc_sel  = PC_JALR;
                ctrl_o.wb_sel  = WB_PC4;
                ctrl_o.illegal = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                ctrl_o.is_branch = 1'b1;
                ctrl_o.pc_sel    = PC_BRANCH;
                ctrl_o.illegal   = (funct3 == 3'b010 || funct3 == 3'b011);
            end
            OPC_SYSTEM: begin
                // Only EBREAK, every other system word traps
                ctrl_o.alu_op    = ALU_PASS_B;
                ctrl_o.is_ebreak = (inst_i == 32'h0010_0073);
                ctrl_o.illegal   = !ctrl_o.is_ebreak;
            end
            default: ctrl_o.illegal = 1'b1;
        endcase

        if (ctrl_o.illegal) begin
            ctrl_o.rf_we     = 1'b0;
            ctrl_o.is_branch = 1'b0;
            ctrl_o.pc_sel    = PC_PLUS4;
        end
    end

endmodule

`default_nettype wire

// File: core/rv_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module rv_fetch #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [31:0]             imem_rdata_i,
    input  rv_pkg::ctrl_t           ctrl_i,
    input  logic                    branch_taken_i,
    input  logic [rv_pkg::XLEN-1:0] target_i,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output rv_pkg::rv_inst_u        inst_o,
    output logic                    inst_valid_o,
    output logic                    halted_o,
    output logic                    trap_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;
    logic            valid_q;
    logic            halted_q;
    logic            trap_q;
    logic            stop;

    assign pc_plus4 = pc_q + XLEN'(4);

    // EBREAK or an illegal word ends the run once it retires
    assign stop = valid_q && !halted_q && (ctrl_i.is_ebreak || ctrl_i.illegal);

    always_comb begin
        if (!valid_q || halted_q || stop) begin
            next_pc = pc_q;
        end else begin
            case (ctrl_i.pc_sel)
                PC_BRANCH: next_pc = branch_taken_i ? target_i : pc_plus4;
                PC_JAL,
                PC_JALR:   next_pc = target_i;
                default:   next_pc = pc_plus4;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q     <= RESET_PC;
            valid_q  <= 1'b0;
            halted_q <= 1'b0;
            trap_q   <= 1'b0;
        end else begin
            pc_q    <= next_pc;
            valid_q <= 1'b1;
            if (stop) begin
                halted_q <= 1'b1;
                trap_q   <= ctrl_i.illegal;
            end
        end
    end

    // Memory registers the word at the next PC
    assign imem_addr_o  = next_pc;
    assign pc_o         = pc_q;
    assign inst_o       = imem_rdata_i;
    assign inst_valid_o = valid_q;
    assign halted_o     = halted_q;
    assign trap_o       = trap_q;

    // Targets from execute must stay word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        pc_q[1:0] == 2'b00)
        else $error("fetch: misaligned pc %h", pc_q);

endmodule

`default_nettype wire

// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } inst_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    // One instruction word, seen through each encoding format
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } rv_inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;
    typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_e;
    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_PC4} wb_sel_e;

    typedef struct packed {
        alu_op_e    alu_op;
        op1_sel_e   op1_sel;
        op2_sel_e   op2_sel;
        pc_sel_e    pc_sel;
        wb_sel_e    wb_sel;
        logic [2:0] funct3;
        logic       rf_we;
        logic       is_branch;
        logic       is_ebreak;
        logic       illegal;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     insn;
        logic            rd_we;
        logic [4:0]      rd;
        logic [XLEN-1:0] rd_data;
    } retire_t;

endpackage

`default_nettype wire
